// ==== audio_params.svh ====
/*
 * audio path build constants
 * sample table geometry and I2S bit-clock divider
 */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// ==========================================================================
// sample table
// ==========================================================================
`define ADDR_W       5   // word address bits
`define DATA_W       16  // mono sample width
`define SAMPLE_COUNT 32  // table words, loader target and player wrap point

// ==========================================================================
// serial clocking
// ==========================================================================
// system clocks per half bit clock
// 4 gives an 8-clock sclk, so one 32-slot frame is 256 clocks
`define SCLK_HALF    4

`endif

// ==== audio_pkg.sv ====
/*
 * audio path shared types
 * Wishbone classic master and slave bundles for the sample store
 */
`default_nettype none

`include "audio_params.svh"

package audio_pkg;

	// ==========================================================================
	// Wishbone classic bundles
	// ==========================================================================

	// master to slave, 24 bits
	typedef struct packed {
		logic               cyc;  // bus cycle in progress
		logic               stb;  // strobe, raised with cyc
		logic               we;   // 1 = write
		logic [`ADDR_W-1:0] adr;  // word address
		logic [`DATA_W-1:0] dat;  // write data
	} wb_req_t;

	// slave to master, 17 bits
	typedef struct packed {
		logic               ack;  // one-cycle acknowledge
		logic [`DATA_W-1:0] dat;  // read data, valid with ack
	} wb_rsp_t;

	// quiet bus, no cycle
	localparam wb_req_t WB_REQ_IDLE = '0;

endpackage

`default_nettype wire

// ==== sample_ram.sv ====
/*
 * sample store, Wishbone classic slave on block RAM
 * one ack per cycle, read data registered and valid with ack
 */
`timescale 1ns/10ps
`default_nettype none

`include "audio_params.svh"

module sample_ram
	import audio_pkg::*;
(
	input  wire          MAX10_CLK1_50,
	input  wire          rst_i,
	input  wire wb_req_t wb_req_i,  // from arbiter
	output wb_rsp_t      wb_rsp_o   // back to arbiter
);

	logic [`DATA_W-1:0] mem_q [`SAMPLE_COUNT];  // the sample table
	logic [`DATA_W-1:0] rd_q;                   // registered read word
	logic               ack_q;                  // ack flag
	logic               hit;                    // access taken this cycle

	// take a new access only when not already acking,
	// master still holds stb in the ack cycle
	assign hit = wb_req_i.cyc && wb_req_i.stb && !ack_q;

	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;  // ack lands the cycle after the request
		end
	end

	// array port, no reset on storage
	always_ff @(posedge MAX10_CLK1_50) begin
		if (hit) begin
			if (wb_req_i.we) begin
				mem_q[wb_req_i.adr] <= wb_req_i.dat;
			end
			rd_q <= mem_q[wb_req_i.adr];  // old word on a write, unused there
		end
	end

	always_comb begin
		wb_rsp_o.ack = ack_q;
		wb_rsp_o.dat = rd_q;
	end

endmodule

`default_nettype wire

// ==== ram_arbiter.sv ====
/*
 * two-master Wishbone arbiter in front of the sample store
 * loader has fixed priority, a grant holds until its owner drops cyc
 */
`timescale 1ns/10ps
`default_nettype none

module ram_arbiter
	import audio_pkg::*;
(
	input  wire          MAX10_CLK1_50,
	input  wire          rst_i,
	input  wire wb_req_t m0_req_i,  // loader
	output wb_rsp_t      m0_rsp_o,
	input  wire wb_req_t m1_req_i,  // player
	output wb_rsp_t      m1_rsp_o,
	output wb_req_t      s_req_o,   // to sample_ram
	input  wire wb_rsp_t s_rsp_i
);

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_LOAD,
		GNT_PLAY
	} gnt_t;

	gnt_t gnt_q;  // owner at end of last cycle
	gnt_t gnt_d;  // owner this cycle

	// ==========================================================================
	// grant
	// ==========================================================================
	always_comb begin
		gnt_d = GNT_IDLE;
		if (gnt_q == GNT_LOAD && m0_req_i.cyc) begin
			gnt_d = GNT_LOAD;  // locked while the loader holds cyc
		end else if (gnt_q == GNT_PLAY && m1_req_i.cyc) begin
			gnt_d = GNT_PLAY;  // same for the player
		end else if (m0_req_i.cyc) begin
			gnt_d = GNT_LOAD;  // free, loader first
		end else if (m1_req_i.cyc) begin
			gnt_d = GNT_PLAY;
		end
	end

	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			gnt_q <= GNT_IDLE;
		end else begin
			gnt_q <= gnt_d;
		end
	end

	// ==========================================================================
	// request mux and ack routing
	// ==========================================================================
	always_comb begin
		case (gnt_d)
			GNT_LOAD: s_req_o = m0_req_i;
			GNT_PLAY: s_req_o = m1_req_i;
			default:  s_req_o = WB_REQ_IDLE;  // nobody on the bus
		endcase
	end

	// data fans out, ack only to the owner
	always_comb begin
		m0_rsp_o.dat = s_rsp_i.dat;
		m0_rsp_o.ack = s_rsp_i.ack && (gnt_d == GNT_LOAD);
		m1_rsp_o.dat = s_rsp_i.dat;
		m1_rsp_o.ack = s_rsp_i.ack && (gnt_d == GNT_PLAY);
	end

endmodule

`default_nettype wire

// ==== sample_loader.sv ====
/*
 * sample loader, external word requests to Wishbone writes
 * pulses begun on each ack, flags when the first full table is in
 */
`timescale 1ns/10ps
`default_nettype none

`include "audio_params.svh"

module sample_loader
	import audio_pkg::*;
(
	input  wire               MAX10_CLK1_50,
	input  wire               rst_i,
	input  wire               ram_we_i,     // word waiting, held until begun
	input  wire [`ADDR_W-1:0] ram_addr_i,
	input  wire [`DATA_W-1:0] ram_data_i,
	output logic              ram_begun_o,  // one cycle, with the RAM ack
	output logic              load_done_o,  // first table complete
	output wb_req_t           wb_req_o,
	input  wire wb_rsp_t      wb_rsp_i
);

	typedef enum logic {
		LD_IDLE,
		LD_BUS
	} ld_state_t;

	ld_state_t          state_q;
	logic [`ADDR_W-1:0] adr_q;   // latched address
	logic [`DATA_W-1:0] dat_q;   // latched sample
	logic [`ADDR_W:0]   cnt_q;   // completed writes, one extra bit to reach 32
	logic               done_q;

	assign ram_begun_o = (state_q == LD_BUS) && wb_rsp_i.ack;
	assign load_done_o = done_q;

	// ==========================================================================
	// bus FSM
	// ==========================================================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			state_q <= LD_IDLE;
		end else begin
			case (state_q)
				LD_IDLE: if (ram_we_i) state_q <= LD_BUS;   // word seen, open cycle
				LD_BUS:  if (wb_rsp_i.ack) state_q <= LD_IDLE;  // drop cyc next cycle
				default: state_q <= LD_IDLE;
			endcase
		end
	end

	// capture the word as the cycle opens
	always_ff @(posedge MAX10_CLK1_50) begin
		if (state_q == LD_IDLE && ram_we_i) begin
			adr_q <= ram_addr_i;
			dat_q <= ram_data_i;
		end
	end

	always_comb begin
		wb_req_o.cyc = (state_q == LD_BUS);
		wb_req_o.stb = (state_q == LD_BUS);
		wb_req_o.we  = 1'b1;  // writes only
		wb_req_o.adr = adr_q;
		wb_req_o.dat = dat_q;
	end

	// ==========================================================================
	// first-table counter
	// ==========================================================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			cnt_q  <= '0;
			done_q <= 1'b0;
		end else if (ram_begun_o && !done_q) begin
			cnt_q <= cnt_q + 1'b1;  // saturates, stops once done
			if (cnt_q == (`ADDR_W+1)'(`SAMPLE_COUNT-1)) begin
				done_q <= 1'b1;  // high the cycle after the last begun
			end
		end
	end

endmodule

`default_nettype wire

// ==== i2s_player.sv ====
/*
 * I2S player, loops over the sample table once started
 * each sample goes out on left and right, MSB first, one-bit delay
 */
`timescale 1ns/10ps
`default_nettype none

`include "audio_params.svh"

module i2s_player
	import audio_pkg::*;
(
	input  wire          MAX10_CLK1_50,
	input  wire          rst_i,
	input  wire          start_i,   // table loaded, level
	output wb_req_t      wb_req_o,  // read master
	input  wire wb_rsp_t wb_rsp_i,
	output logic         sclk_o,    // bit clock
	output logic         lrclk_o,   // word select, low = left
	output logic         sdata_o    // serial data
);

	localparam int DIV_W = $clog2(`SCLK_HALF);   // half-period counter
	localparam int BIT_W = $clog2(2 * `DATA_W);  // slot counter, 5 bits

	logic               run_q;      // playing
	logic [DIV_W-1:0]   div_q;
	logic               sclk_q;
	logic               lrclk_q;
	logic               sdata_q;
	logic [BIT_W-1:0]   bit_q;      // current slot in the frame
	logic [BIT_W-1:0]   slot_nx;    // slot after the next falling edge
	logic               tick;       // sclk toggles
	logic               fall;       // sclk falls
	logic               left_start;
	logic               right_start;
	logic               cyc_q;      // read in flight
	logic [`ADDR_W-1:0] rd_addr_q;  // next table word to fetch
	logic [`DATA_W-1:0] pref_q;     // prefetched next sample
	logic [`DATA_W-1:0] cur_q;      // sample of this frame, for the right word
	logic [`DATA_W-1:0] shift_q;

	assign tick        = run_q && (div_q == DIV_W'(`SCLK_HALF - 1));
	assign fall        = tick && sclk_q;
	assign slot_nx     = bit_q + 1'b1;  // wraps 31 -> 0
	assign left_start  = fall && (slot_nx == '0);
	assign right_start = fall && (slot_nx == BIT_W'(`DATA_W));

	// ==========================================================================
	// bit clock and word select
	// ==========================================================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			run_q   <= 1'b0;
			div_q   <= '0;
			sclk_q  <= 1'b0;
			lrclk_q <= 1'b0;
			bit_q   <= '1;  // first falling edge opens slot 0
		end else begin
			if (start_i) run_q <= 1'b1;
			if (tick) begin
				div_q  <= '0;
				sclk_q <= ~sclk_q;
			end else if (run_q) begin
				div_q <= div_q + 1'b1;
			end
			if (fall) begin
				bit_q   <= slot_nx;
				lrclk_q <= slot_nx[BIT_W-1];  // upper half of the frame is right
			end
		end
	end

	// ==========================================================================
	// sample prefetch
	// ==========================================================================
	// first read fires as playback starts, then one per frame at the left start
	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			cyc_q     <= 1'b0;
			rd_addr_q <= '0;
		end else if (cyc_q && wb_rsp_i.ack) begin
			cyc_q     <= 1'b0;  // drop after ack
			rd_addr_q <= (rd_addr_q == `ADDR_W'(`SAMPLE_COUNT - 1)) ? '0 : rd_addr_q + 1'b1;
		end else if ((start_i && !run_q) || left_start) begin
			cyc_q <= 1'b1;
		end
	end

	always_ff @(posedge MAX10_CLK1_50) begin
		if (cyc_q && wb_rsp_i.ack) pref_q <= wb_rsp_i.dat;
		if (left_start) cur_q <= pref_q;  // keep for the right word
	end

	always_comb begin
		wb_req_o.cyc = cyc_q;
		wb_req_o.stb = cyc_q;
		wb_req_o.we  = 1'b0;  // reads only
		wb_req_o.adr = rd_addr_q;
		wb_req_o.dat = '0;
	end

	// ==========================================================================
	// serial shifter
	// ==========================================================================
	// the MSB leaves one slot after each load, so the word trails lrclk by a bit
	always_ff @(posedge MAX10_CLK1_50) begin
		if (rst_i) begin
			shift_q <= '0;
			sdata_q <= 1'b0;
		end else if (fall) begin
			sdata_q <= shift_q[`DATA_W-1];  // last bit of the old word on a load
			if (left_start) begin
				shift_q <= pref_q;
			end else if (right_start) begin
				shift_q <= cur_q;  // same sample again
			end else begin
				shift_q <= shift_q << 1;
			end
		end
	end

	assign sclk_o  = sclk_q;
	assign lrclk_o = lrclk_q;
	assign sdata_o = sdata_q;

endmodule

`default_nettype wire

// ==== audio_stream_top.sv ====
/*
 * audio stream top, loader and I2S player sharing the sample store
 * through the Wishbone arbiter
 */
`timescale 1ns/10ps
`default_nettype none

`include "audio_params.svh"

module audio_stream_top
	import audio_pkg::*;
(
	input  wire               MAX10_CLK1_50,
	input  wire               rst_i,
	// card reader side
	input  wire               ram_we_i,
	input  wire [`ADDR_W-1:0] ram_addr_i,
	input  wire [`DATA_W-1:0] ram_data_i,
	output wire               ram_begun_o,
	output wire               load_done_o,
	// I2S out
	output wire               sclk_o,
	output wire               lrclk_o,
	output wire               sdata_o
);

	wb_req_t ld_req;  // loader master
	wb_rsp_t ld_rsp;
	wb_req_t pl_req;  // player master
	wb_rsp_t pl_rsp;
	wb_req_t mem_req;  // arbiter to RAM
	wb_rsp_t mem_rsp;

	sample_loader u_loader (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst_i         (rst_i),
		.ram_we_i      (ram_we_i),
		.ram_addr_i    (ram_addr_i),
		.ram_data_i    (ram_data_i),
		.ram_begun_o   (ram_begun_o),
		.load_done_o   (load_done_o),
		.wb_req_o      (ld_req),
		.wb_rsp_i      (ld_rsp)
	);

	i2s_player u_player (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst_i         (rst_i),
		.start_i       (load_done_o),  // play once the table is in
		.wb_req_o      (pl_req),
		.wb_rsp_i      (pl_rsp),
		.sclk_o        (sclk_o),
		.lrclk_o       (lrclk_o),
		.sdata_o       (sdata_o)
	);

	ram_arbiter u_arbiter (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst_i         (rst_i),
		.m0_req_i      (ld_req),  // loader wins ties
		.m0_rsp_o      (ld_rsp),
		.m1_req_i      (pl_req),
		.m1_rsp_o      (pl_rsp),
		.s_req_o       (mem_req),
		.s_rsp_i       (mem_rsp)
	);

	sample_ram u_ram (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst_i         (rst_i),
		.wb_req_i      (mem_req),
		.wb_rsp_o      (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
/*
 * testbench clock and reset source
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2 rst_o = 1'b0;  // released just after an edge
	end

endmodule

`default_nettype wire

// ==== audio_stream_tb.sv ====
/*
 * audio stream testbench, loads the trace table, refreshes it during playback
 * and decodes the I2S output against the expected sample order
 */
`timescale 1ns/10ps
`default_nettype none

`include "audio_params.svh"

module audio_stream_tb;

	localparam int    PERIOD_NS    = 20;
	localparam int    RESET_CYCLES = 16;
	localparam int    SEED         = 92;
	localparam int    TRACE_WORDS  = `SAMPLE_COUNT + 8;  // table plus refresh
	localparam int    FRAME_TOTAL  = 70;                 // two passes and a bit
	localparam time   WINDOW_NS    = 640 * PERIOD_NS;    // old value still legal
	localparam time   WATCHDOG_NS  = (40 * 6 + 80 * 256) * PERIOD_NS + 50000;
	localparam string TRACE_FILE   = "audio_trace.txt";

	wire                MAX10_CLK1_50;
	wire                rst_i;
	logic               ram_we_i;
	logic [`ADDR_W-1:0] ram_addr_i;
	logic [`DATA_W-1:0] ram_data_i;
	wire                ram_begun_o;
	wire                load_done_o;
	wire                sclk_o;
	wire                lrclk_o;
	wire                sdata_o;

	logic [`DATA_W-1:0] trace_mem [TRACE_WORDS];
	logic [`DATA_W-1:0] exp_tab [`SAMPLE_COUNT];  // what the RAM should hold
	logic [`DATA_W-1:0] old_tab [`SAMPLE_COUNT];  // value before a refresh
	time                wr_time [`SAMPLE_COUNT];
	logic               wr_seen [`SAMPLE_COUNT];
	int                 begun_cnt;
	int                 frames_done;
	int                 play_addr;  // table word the next frame carries
	int                 err_cnt;
	logic [`DATA_W-1:0] acc_q;      // serial bits of the current word
	logic [`DATA_W-1:0] left_word;
	logic               prev_lr;

	tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk_o (MAX10_CLK1_50),
		.rst_o (rst_i)
	);

	audio_stream_top UUT (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst_i         (rst_i),
		.ram_we_i      (ram_we_i),
		.ram_addr_i    (ram_addr_i),
		.ram_data_i    (ram_data_i),
		.ram_begun_o   (ram_begun_o),
		.load_done_o   (load_done_o),
		.sclk_o        (sclk_o),
		.lrclk_o       (lrclk_o),
		.sdata_o       (sdata_o)
	);

	// ==========================================================================
	// checking
	// ==========================================================================
	task automatic fail_run(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
	                           input logic [15:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// ==========================================================================
	// load side
	// ==========================================================================
	task automatic present_word(input int idx);
		logic [`ADDR_W-1:0] a;
		int                 gap;
		a = `ADDR_W'(idx % `SAMPLE_COUNT);
		@(posedge MAX10_CLK1_50);
		#2;
		ram_we_i   = 1'b1;
		ram_addr_i = a;
		ram_data_i = trace_mem[idx];
		@(negedge MAX10_CLK1_50);
		while (!ram_begun_o) @(negedge MAX10_CLK1_50);  // latency varies
		check_value("load_done_o", 16'(idx >= `SAMPLE_COUNT), 16'(load_done_o));
		if (idx >= `SAMPLE_COUNT) begin  // refresh word now in the RAM
			old_tab[a] = exp_tab[a];
			exp_tab[a] = trace_mem[idx];
			wr_time[a] = $time;
			wr_seen[a] = 1'b1;
		end
		@(posedge MAX10_CLK1_50);
		#2 ram_we_i = 1'b0;
		@(negedge MAX10_CLK1_50);
		check_value("ram_begun_o", 16'h0, 16'(ram_begun_o));  // single pulse
		check_value("begun_count", 16'(idx + 1), 16'(begun_cnt));
		check_value("load_done_o", 16'(idx >= `SAMPLE_COUNT - 1), 16'(load_done_o));
		gap = int'($urandom % 4);
		repeat (gap) @(posedge MAX10_CLK1_50);
	endtask

	// begun count, and a quiet I2S side until the table is in
	always @(negedge MAX10_CLK1_50) begin
		if (ram_begun_o) begun_cnt++;
		if (!rst_i && !load_done_o) begin
			check_value("sclk_o", 16'h0, 16'(sclk_o));
			check_value("lrclk_o", 16'h0, 16'(lrclk_o));
			check_value("sdata_o", 16'h0, 16'(sdata_o));
		end
	end

	// ==========================================================================
	// I2S receiver
	// ==========================================================================
	task automatic check_frame(input logic [15:0] right_word);
		logic [15:0] want;
		want = exp_tab[play_addr];
		// prefetch may have read the word just before a refresh
		if (wr_seen[play_addr] && ($time - wr_time[play_addr] < WINDOW_NS) &&
		    left_word == old_tab[play_addr]) begin
			want = old_tab[play_addr];
		end
		check_value("sdata_o left word", want, left_word);
		check_value("sdata_o right word", left_word, right_word);
		play_addr = (play_addr + 1) % `SAMPLE_COUNT;  // wraps after word 31
		frames_done++;
	endtask

	// lrclk change slot carries the LSB of the word that just ended
	always @(posedge sclk_o) begin
		if (lrclk_o != prev_lr) begin
			if (!prev_lr) left_word = {acc_q[`DATA_W-2:0], sdata_o};
			else check_frame({acc_q[`DATA_W-2:0], sdata_o});
			acc_q = '0;
		end else begin
			acc_q = {acc_q[`DATA_W-2:0], sdata_o};  // MSB first
		end
		prev_lr = lrclk_o;
	end

	// ==========================================================================
	// main sequence
	// ==========================================================================
	initial begin
		int fd;
		int k;
		ram_we_i    = 1'b0;
		ram_addr_i  = '0;
		ram_data_i  = '0;
		begun_cnt   = 0;
		frames_done = 0;
		play_addr   = 0;
		err_cnt     = 0;
		acc_q       = '0;
		left_word   = '0;
		prev_lr     = 1'b0;
		void'($urandom(SEED));
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) fail_run("trace file audio_trace.txt could not be opened");
		else $fclose(fd);
		$readmemh(TRACE_FILE, trace_mem);
		for (k = 0; k < `SAMPLE_COUNT; k++) begin
			exp_tab[k] = trace_mem[k];
			old_tab[k] = trace_mem[k];
			wr_time[k] = 0;
			wr_seen[k] = 1'b0;
		end
		@(negedge rst_i);
		for (k = 0; k < TRACE_WORDS; k++) begin
			if (k == `SAMPLE_COUNT) wait (load_done_o);  // refresh while playing
			present_word(k);
		end
		wait (frames_done >= FRAME_TOTAL);
		@(posedge MAX10_CLK1_50);
		if (err_cnt == 0) $display("Done: no errors");
		else $display("Done: errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, playback did not reach %0d checked frames", FRAME_TOTAL);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== audio_trace.txt ====
// 16-bit hex sample words, eight per line, read in order with $readmemh
// words 0-31 are the table for addresses 0-31, words 32-39 refresh addresses 0-7
8001 7FFE 1234 EDCB 0F0F F0F0 5A5A A5A5
0001 8000 C3C3 3C3C FF00 00FF 1357 2468
9ABC DEF0 4321 8765 AAAA 5555 6DB6 B6DB
0123 4567 89AB CDEF FEDC BA98 7654 3210
// refresh section
1111 2222 3333 4444 6666 7777 9999 BBBB

// ==== files.f ====
+incdir+.
audio_pkg.sv
sample_ram.sv
ram_arbiter.sv
sample_loader.sv
i2s_player.sv
audio_stream_top.sv
tb_clock_gen.sv
audio_stream_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the audio stream testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module audio_stream_tb -f files.f -o sim_audio \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_audio > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
